//--- rtl/hyper_pkg.sv
// Shared types and constants for the HyperBus controller
// Imported by the RTL modules and by the behavioural memory model
`default_nettype none

package hyper_pkg;

    // Command-address phase and data phase sizes
    localparam int CA_BYTES   = 6;
    localparam int WORD_BYTES = 4;

    // Register window layout
    localparam int                  REG_ADR_W   = 8;
    localparam logic [REG_ADR_W-1:0] REG_CFG    = 8'h00;
    localparam logic [REG_ADR_W-1:0] REG_STATUS = 8'h04;

    // CFG fields and their reset values
    localparam int               LAT_W       = 4;
    localparam logic [LAT_W-1:0] LAT_RESET   = 4'd6;
    localparam logic [LAT_W-1:0] LAT_MIN     = 4'd3;
    localparam int               CFG_RST_BIT = 8;

    // Command-address word, seen as fields or as the bytes on DQ
    // bytes[5] leaves first
    typedef union packed {
        struct packed {
            logic        rw;
            logic        addr_space;
            logic        burst_type;
            logic [28:0] row;
            logic [12:0] reserved;
            logic [2:0]  col;
        } f;
        logic [CA_BYTES-1:0][7:0] bytes;
    } ca_word_u;

endpackage

`default_nettype wire

//--- rtl/hyper_cfg_regs.sv
// Configuration and status registers of the HyperBus controller
// CFG holds the latency and the device reset bit, STATUS counts memory transactions
// Accessed through the register window of the Wishbone responder
`timescale 1ns/1ps
`default_nettype none

module hyper_cfg_regs (
    input  logic                             sys_clk,
    input  logic                             rst_n_i,
    input  logic                             reg_stb_i,
    input  logic                             req_we_i,
    input  logic [hyper_pkg::REG_ADR_W-1:0]  req_adr_i,
    input  logic [31:0]                      req_wdat_i,
    input  logic                             txn_done_i,
    output logic                             reg_ack_o,
    output logic                             reg_err_o,
    output logic [31:0]                      reg_rdat_o,
    output logic [hyper_pkg::LAT_W-1:0]      cfg_latency_o,
    output logic                             hyper_reset_n_o
);
    import hyper_pkg::*;

    logic [LAT_W-1:0] lat_q;
    logic             dev_rst_n_q;
    logic [15:0]      txn_cnt_q;
    logic [LAT_W-1:0] lat_wr;
    logic [31:0]      cfg_word;
    logic             is_cfg;
    logic             is_status;

    assign is_cfg    = (req_adr_i == REG_CFG);
    assign is_status = (req_adr_i == REG_STATUS);

    // Clamp too short latencies
    assign lat_wr = (req_wdat_i[LAT_W-1:0] < LAT_MIN) ? LAT_MIN : req_wdat_i[LAT_W-1:0];

    always_comb begin
        cfg_word              = '0;
        cfg_word[LAT_W-1:0]   = lat_q;
        cfg_word[CFG_RST_BIT] = dev_rst_n_q;
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            lat_q       <= LAT_RESET;
            dev_rst_n_q <= 1'b1;
            txn_cnt_q   <= '0;
            reg_ack_o   <= 1'b0;
            reg_err_o   <= 1'b0;
        end else begin
            reg_ack_o <= 1'b0;
            reg_err_o <= 1'b0;
            if (txn_done_i) begin
                txn_cnt_q <= txn_cnt_q + 16'd1;
            end
            if (reg_stb_i) begin
                if (req_we_i) begin
                    // STATUS is read only
                    if (is_cfg) begin
                        lat_q       <= lat_wr;
                        dev_rst_n_q <= req_wdat_i[CFG_RST_BIT];
                        reg_ack_o   <= 1'b1;
                    end else begin
                        reg_err_o <= 1'b1;
                    end
                end else begin
                    reg_ack_o <= is_cfg | is_status;
                    reg_err_o <= ~(is_cfg | is_status);
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reg_stb_i && !req_we_i) begin
            reg_rdat_o <= is_status ? {16'h0000, txn_cnt_q} : cfg_word;
        end
    end

    assign cfg_latency_o   = lat_q;
    assign hyper_reset_n_o = dev_rst_n_q;

endmodule

`default_nettype wire

//--- rtl/hyper_txn_engine.sv
// HyperBus transaction engine, one 32-bit word per transaction
// Sends the command-address word, waits the configured latency, then moves four bytes
// Started by a one-cycle strobe, ends with mem_ack_o and txn_done_o
`timescale 1ns/1ps
`default_nettype none

module hyper_txn_engine #(
    parameter int MemAddrWidth = 12
) (
    input  logic                        sys_clk,
    input  logic                        rst_n_i,
    input  logic                        mem_stb_i,
    input  logic                        req_we_i,
    input  logic [MemAddrWidth-1:0]     req_adr_i,
    input  logic [3:0]                  req_sel_i,
    input  logic [31:0]                 req_wdat_i,
    input  logic [hyper_pkg::LAT_W-1:0] cfg_latency_i,
    input  logic [7:0]                  hyper_dq_i,
    input  logic                        hyper_rwds_i,
    output logic                        mem_ack_o,
    output logic [31:0]                 mem_rdat_o,
    output logic                        txn_done_o,
    output logic                        hyper_cs_n_o,
    output logic                        hyper_ck_o,
    output logic                        hyper_ck_n_o,
    output logic [7:0]                  hyper_dq_o,
    output logic                        hyper_dq_oe_o,
    output logic                        hyper_rwds_o,
    output logic                        hyper_rwds_oe_o
);
    import hyper_pkg::*;

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_CA     = 3'd1;
    localparam logic [2:0] ST_LAT    = 3'd2;
    localparam logic [2:0] ST_DATA   = 3'd3;
    localparam logic [2:0] ST_FINISH = 3'd4;

    logic [2:0]       state_q;
    logic [2:0]       cnt_q;
    logic [LAT_W-1:0] lat_cnt_q;
    logic             ck_q;
    ca_word_u         ca_d;
    ca_word_u         ca_q;
    logic             we_q;
    logic [3:0]       sel_q;
    logic [31:0]      wdat_q;
    logic [31:0]      rdat_q;
    logic             launch;
    logic             bus_active;
    logic             byte_take;

    assign launch     = (state_q == ST_IDLE) && mem_stb_i;
    assign bus_active = (state_q == ST_CA) || (state_q == ST_LAT) || (state_q == ST_DATA);
    // Writes move a byte every cycle, reads wait for RWDS
    assign byte_take  = (state_q == ST_DATA) && (we_q || hyper_rwds_i);

    // Byte address to 16-bit word address, row above the 3-bit column
    always_comb begin
        ca_d              = '0;
        ca_d.f.rw         = ~req_we_i;
        ca_d.f.addr_space = 1'b0;
        ca_d.f.burst_type = 1'b1;
        ca_d.f.row        = 29'(req_adr_i >> 4);
        ca_d.f.col        = req_adr_i[3:1];
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            lat_cnt_q <= '0;
            ck_q      <= 1'b0;
        end else begin
            ck_q <= bus_active ? ~ck_q : 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (mem_stb_i) begin
                        state_q   <= ST_CA;
                        cnt_q     <= '0;
                        lat_cnt_q <= cfg_latency_i;
                    end
                end
                ST_CA: begin
                    if (cnt_q == 3'(CA_BYTES - 1)) begin
                        state_q <= ST_LAT;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                end
                ST_LAT: begin
                    // One cycle per count, down to 1
                    lat_cnt_q <= lat_cnt_q - LAT_W'(1);
                    if (lat_cnt_q == LAT_W'(1)) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (byte_take) begin
                        cnt_q <= cnt_q + 3'd1;
                        if (cnt_q == 3'(WORD_BYTES - 1)) begin
                            state_q <= ST_FINISH;
                        end
                    end
                end
                ST_FINISH: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request capture and byte shifting
    always_ff @(posedge sys_clk) begin
        if (launch) begin
            ca_q   <= ca_d;
            we_q   <= req_we_i;
            sel_q  <= req_sel_i;
            wdat_q <= req_wdat_i;
        end else if (state_q == ST_CA) begin
            ca_q.bytes <= {ca_q.bytes[CA_BYTES-2:0], 8'h00};
        end else if (byte_take) begin
            // Lowest byte lane goes first on DQ
            wdat_q <= {8'h00, wdat_q[31:8]};
            sel_q  <= {1'b0, sel_q[3:1]};
            if (!we_q) begin
                rdat_q <= {hyper_dq_i, rdat_q[31:8]};
            end
        end
    end

    assign hyper_cs_n_o    = ~bus_active;
    assign hyper_ck_o      = ck_q & bus_active;
    assign hyper_ck_n_o    = ~hyper_ck_o;
    assign hyper_dq_o      = (state_q == ST_CA) ? ca_q.bytes[CA_BYTES-1] : wdat_q[7:0];
    assign hyper_dq_oe_o   = (state_q == ST_CA) || ((state_q == ST_DATA) && we_q);
    assign hyper_rwds_oe_o = (state_q == ST_DATA) && we_q;
    // RWDS high masks the byte
    assign hyper_rwds_o    = hyper_rwds_oe_o & ~sel_q[0];

    assign mem_ack_o  = (state_q == ST_FINISH);
    assign txn_done_o = (state_q == ST_FINISH);
    assign mem_rdat_o = rdat_q;

endmodule

`default_nettype wire

//--- rtl/hyper_wb_resp.sv
// Wishbone classic slave front end of the HyperBus controller
// Splits requests between the register block and the transaction engine
// and merges their answers into one response
`timescale 1ns/1ps
`default_nettype none

module hyper_wb_resp #(
    parameter int MemAddrWidth = 12
) (
    input  logic                    sys_clk,
    input  logic                    rst_n_i,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [31:0]             wb_adr_i,
    input  logic [3:0]              wb_sel_i,
    input  logic [31:0]             wb_dat_i,
    input  logic                    reg_ack_i,
    input  logic                    reg_err_i,
    input  logic [31:0]             reg_rdat_i,
    input  logic                    mem_ack_i,
    input  logic [31:0]             mem_rdat_i,
    output logic                    reg_stb_o,
    output logic                    mem_stb_o,
    output logic                    req_we_o,
    output logic [MemAddrWidth-1:0] req_adr_o,
    output logic [3:0]              req_sel_o,
    output logic [31:0]             req_wdat_o,
    output logic [31:0]             wb_dat_o,
    output logic                    wb_ack_o,
    output logic                    wb_err_o
);
    import hyper_pkg::*;

    logic launch;
    logic reg_win;
    logic bad_adr;
    logic pending_q;
    logic loc_err_q;

    assign launch  = wb_cyc_i & wb_stb_i & ~pending_q;
    assign reg_win = wb_adr_i[MemAddrWidth];
    // Offsets beyond the register block, or unaligned memory words
    assign bad_adr = reg_win ? (|wb_adr_i[MemAddrWidth-1:REG_ADR_W]) : (|wb_adr_i[1:0]);

    assign reg_stb_o  = launch & reg_win & ~bad_adr;
    assign mem_stb_o  = launch & ~reg_win & ~bad_adr;
    assign req_we_o   = wb_we_i;
    assign req_adr_o  = wb_adr_i[MemAddrWidth-1:0];
    assign req_sel_o  = wb_sel_i;
    assign req_wdat_o = wb_dat_i;

    always_ff @(posedge sys_clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            loc_err_q <= 1'b0;
        end else begin
            loc_err_q <= launch & bad_adr;
            if (launch) begin
                pending_q <= 1'b1;
            end else if (wb_ack_o || wb_err_o) begin
                pending_q <= 1'b0;
            end
        end
    end

    // All sources are registered
    assign wb_ack_o = reg_ack_i | mem_ack_i;
    assign wb_err_o = reg_err_i | loc_err_q;
    assign wb_dat_o = mem_ack_i ? mem_rdat_i : reg_rdat_i;

endmodule

`default_nettype wire

//--- rtl/hyper_ctrl_top.sv
// Top level of the Wishbone to HyperBus memory controller
// Upper half of the address window reaches the registers, lower half the memory
`timescale 1ns/1ps
`default_nettype none

module hyper_ctrl_top #(
    parameter int MemAddrWidth = 12
) (
    input  logic        sys_clk,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        wb_err_o,
    output logic        hyper_cs_n_o,
    output logic        hyper_ck_o,
    output logic        hyper_ck_n_o,
    output logic        hyper_reset_n_o,
    output logic [7:0]  hyper_dq_o,
    output logic        hyper_dq_oe_o,
    input  logic [7:0]  hyper_dq_i,
    output logic        hyper_rwds_o,
    output logic        hyper_rwds_oe_o,
    input  logic        hyper_rwds_i
);
    import hyper_pkg::*;

    logic                    reg_stb;
    logic                    mem_stb;
    logic                    req_we;
    logic [MemAddrWidth-1:0] req_adr;
    logic [3:0]              req_sel;
    logic [31:0]             req_wdat;
    logic                    reg_ack;
    logic                    reg_err;
    logic [31:0]             reg_rdat;
    logic                    mem_ack;
    logic [31:0]             mem_rdat;
    logic [LAT_W-1:0]        cfg_latency;
    logic                    txn_done;

    hyper_wb_resp #(
        .MemAddrWidth (MemAddrWidth)
    ) i_wb_resp (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_i   (wb_dat_i),
        .reg_ack_i  (reg_ack),
        .reg_err_i  (reg_err),
        .reg_rdat_i (reg_rdat),
        .mem_ack_i  (mem_ack),
        .mem_rdat_i (mem_rdat),
        .reg_stb_o  (reg_stb),
        .mem_stb_o  (mem_stb),
        .req_we_o   (req_we),
        .req_adr_o  (req_adr),
        .req_sel_o  (req_sel),
        .req_wdat_o (req_wdat),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o)
    );

    // Register offset is the low part of the window address
    hyper_cfg_regs i_cfg_regs (
        .sys_clk         (sys_clk),
        .rst_n_i         (rst_n_i),
        .reg_stb_i       (reg_stb),
        .req_we_i        (req_we),
        .req_adr_i       (req_adr[REG_ADR_W-1:0]),
        .req_wdat_i      (req_wdat),
        .txn_done_i      (txn_done),
        .reg_ack_o       (reg_ack),
        .reg_err_o       (reg_err),
        .reg_rdat_o      (reg_rdat),
        .cfg_latency_o   (cfg_latency),
        .hyper_reset_n_o (hyper_reset_n_o)
    );

    hyper_txn_engine #(
        .MemAddrWidth (MemAddrWidth)
    ) i_txn_engine (
        .sys_clk         (sys_clk),
        .rst_n_i         (rst_n_i),
        .mem_stb_i       (mem_stb),
        .req_we_i        (req_we),
        .req_adr_i       (req_adr),
        .req_sel_i       (req_sel),
        .req_wdat_i      (req_wdat),
        .cfg_latency_i   (cfg_latency),
        .hyper_dq_i      (hyper_dq_i),
        .hyper_rwds_i    (hyper_rwds_i),
        .mem_ack_o       (mem_ack),
        .mem_rdat_o      (mem_rdat),
        .txn_done_o      (txn_done),
        .hyper_cs_n_o    (hyper_cs_n_o),
        .hyper_ck_o      (hyper_ck_o),
        .hyper_ck_n_o    (hyper_ck_n_o),
        .hyper_dq_o      (hyper_dq_o),
        .hyper_dq_oe_o   (hyper_dq_oe_o),
        .hyper_rwds_o    (hyper_rwds_o),
        .hyper_rwds_oe_o (hyper_rwds_oe_o)
    );

endmodule

`default_nettype wire

//--- verif/hyper_mem_model.sv
// Behavioural HyperBus memory for the controller testbench
// Decodes the command-address word, checks the write latency against exp_lat_i
// and answers reads after 0 to 3 random extra cycles with RWDS high per byte
`timescale 1ns/1ps
`default_nettype none

module hyper_mem_model #(
    parameter int MemAddrWidth = 12
) (
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic       cs_n_i,
    input  logic [7:0] dq_i,
    input  logic       dq_oe_i,
    input  logic       rwds_i,
    input  logic       rwds_oe_i,
    input  logic [3:0] exp_lat_i,
    output logic [7:0] dq_o,
    output logic       rwds_o,
    output logic       lat_err_o
);
    import hyper_pkg::*;

    localparam int MemBytes = 1 << MemAddrWidth;

    logic [7:0]              mem [MemBytes];
    ca_word_u                ca_q;
    int unsigned             k;
    int unsigned             nbyte;
    int unsigned             extra;
    logic                    seen_data;
    logic [MemAddrWidth-1:0] base;

    // Row and column back to a byte address
    assign base = MemAddrWidth'({ca_q.f.row, ca_q.f.col, 1'b0});

    initial begin
        for (int a = 0; a < MemBytes; a++) begin
            mem[a] = 8'((a * 7) ^ (a >> 8) ^ 8'h5a);
        end
        dq_o      = 8'h00;
        rwds_o    = 1'b0;
        lat_err_o = 1'b0;
        ca_q      = '0;
        extra     = 0;
    end

    always @(posedge sys_clk) begin
        lat_err_o <= 1'b0;
        if (!rst_n_i || cs_n_i) begin
            k         <= 0;
            nbyte     <= 0;
            seen_data <= 1'b0;
            rwds_o    <= 1'b0;
            dq_o      <= 8'h00;
        end else begin
            k <= k + 1;
            if (k < CA_BYTES) begin
                ca_q.bytes[CA_BYTES-1-k] <= dq_i;
                if (k == CA_BYTES - 1) begin
                    extra <= $urandom % 4;
                end
            end else if (!ca_q.f.rw) begin
                if (dq_oe_i && rwds_oe_i) begin
                    // First data byte must follow exactly the latency
                    if (!seen_data && (k != CA_BYTES + exp_lat_i)) begin
                        lat_err_o <= 1'b1;
                    end
                    seen_data <= 1'b1;
                    if (!rwds_i) begin
                        mem[base + MemAddrWidth'(nbyte)] <= dq_i;
                    end
                    nbyte <= nbyte + 1;
                end
            end else begin
                // Byte shows up in the cycle after this edge
                if ((k + 1 >= CA_BYTES + exp_lat_i + extra) && (nbyte < WORD_BYTES)) begin
                    rwds_o <= 1'b1;
                    dq_o   <= mem[base + MemAddrWidth'(nbyte)];
                    nbyte  <= nbyte + 1;
                end else begin
                    rwds_o <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/hyper_ctrl_properties.sv
// Interface assertions for the HyperBus controller, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module hyper_ctrl_properties (
    input logic sys_clk,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic wb_err_o,
    input logic hyper_cs_n_o,
    input logic hyper_dq_oe_o
);

    ack_err_excl: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        !(wb_ack_o && wb_err_o))
        else $error("ack and err high in the same cycle");

    resp_needs_req: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        (wb_ack_o || wb_err_o) |-> (wb_cyc_i && wb_stb_i))
        else $error("response given without cyc and stb");

    dq_only_selected: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        hyper_dq_oe_o |-> !hyper_cs_n_o)
        else $error("DQ driven while chip select is inactive");

    // Bus idle right after reset
    cs_idle_after_rst: assert property (@(posedge sys_clk)
        !rst_n_i |=> hyper_cs_n_o)
        else $error("chip select active in the cycle after reset");

endmodule

bind hyper_ctrl_top hyper_ctrl_properties i_props (.*);

`default_nettype wire

//--- verif/hyper_ctrl_tb.sv
// Testbench for the Wishbone to HyperBus controller
// Drives register and memory accesses, assertions compare the responses
`timescale 1ns/1ps
`default_nettype none

module hyper_ctrl_tb;
    import hyper_pkg::*;

    localparam int MemAddrWidth = 12;
    localparam int NumAccess    = 50;
    localparam int CycleLimit   = 40 * NumAccess;

    logic        sys_clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic        cs_n;
    logic        ck;
    logic        ck_n;
    logic        dev_rst_n;
    logic [7:0]  dq_out;
    logic        dq_oe;
    logic [7:0]  dq_in;
    logic        rwds_out;
    logic        rwds_oe;
    logic        rwds_in;
    logic        lat_err;
    logic [3:0]  exp_lat;
    logic [31:0] exp_dat;
    logic        exp_err;
    logic        chk_rd;
    logic [31:0] sb [1 << (MemAddrWidth - 2)];
    int          data_errs;
    int          resp_errs;
    int          lat_errs;
    int          bus_errs;
    int          mem_issued;
    int          cycles;
    int          idx;
    logic [3:0]  sel;
    logic [31:0] val;

    hyper_ctrl_top #(.MemAddrWidth(MemAddrWidth)) dut (
        .sys_clk(sys_clk), .rst_n_i(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_sel_i(wb_sel), .wb_dat_i(wb_dat), .wb_dat_o(wb_dat_o),
        .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
        .hyper_cs_n_o(cs_n), .hyper_ck_o(ck), .hyper_ck_n_o(ck_n),
        .hyper_reset_n_o(dev_rst_n), .hyper_dq_o(dq_out), .hyper_dq_oe_o(dq_oe),
        .hyper_dq_i(dq_in), .hyper_rwds_o(rwds_out), .hyper_rwds_oe_o(rwds_oe),
        .hyper_rwds_i(rwds_in)
    );

    hyper_mem_model #(.MemAddrWidth(MemAddrWidth)) i_mem (
        .sys_clk(sys_clk), .rst_n_i(rst_n), .cs_n_i(cs_n), .dq_i(dq_out),
        .dq_oe_i(dq_oe), .rwds_i(rwds_out), .rwds_oe_i(rwds_oe), .exp_lat_i(exp_lat),
        .dq_o(dq_in), .rwds_o(rwds_in), .lat_err_o(lat_err)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    rdata_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (wb_ack_o && chk_rd) |-> (wb_dat_o == exp_dat))
        else begin
            data_errs++;
            $error("mismatch wb_dat_o: expected %h, got %h", exp_dat, $sampled(wb_dat_o));
        end

    resp_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (wb_ack_o || wb_err_o) |-> (wb_err_o == exp_err))
        else begin
            resp_errs++;
            $error("mismatch wb_err_o: expected %h, got %h", exp_err, $sampled(wb_err_o));
        end

    latency_check: assert property (@(posedge sys_clk) disable iff (!rst_n) !lat_err)
        else begin
            lat_errs++;
            $error("memory model saw the first write byte at the wrong latency");
        end

    // One clock edge per byte cycle while selected
    ck_toggle_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
        (!cs_n && $past(!cs_n)) |-> (ck != $past(ck)))
        else begin
            bus_errs++;
            $error("HyperBus clock did not toggle while chip select was active");
        end

    ck_pair_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
        ck_n == ~ck)
        else begin
            bus_errs++;
            $error("mismatch hyper_ck_n_o: expected %h, got %h",
                   ~$sampled(ck), $sampled(ck_n));
        end

    // Every CFG write keeps the device out of reset
    dev_reset_check: assert property (@(posedge sys_clk) disable iff (!rst_n)
        dev_rst_n == 1'b1)
        else begin
            bus_errs++;
            $error("mismatch hyper_reset_n_o: expected %h, got %h",
                   1'b1, $sampled(dev_rst_n));
        end

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] reg_adr(input logic [7:0] off);
        return (32'd1 << MemAddrWidth) | {24'h0, off};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return res;
    endfunction

    // One classic cycle, held until ack or err
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [3:0] be,
                              input logic [31:0] wdat, input logic [31:0] rexp,
                              input logic err_exp);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_sel  = be;
        wb_dat  = wdat;
        exp_dat = rexp;
        exp_err = err_exp;
        chk_rd  = !we && !err_exp;
        do @(posedge sys_clk); while (!(wb_ack_o || wb_err_o));
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        chk_rd = 1'b0;
        @(posedge sys_clk);
        #0.5;
    endtask

    task automatic mem_write(input int widx, input logic [3:0] be, input logic [31:0] wdat);
        bus_access(1'b1, 32'(widx * 4), be, wdat, 32'h0, 1'b0);
        sb[widx] = merge_bytes(sb[widx], wdat, be);
        mem_issued++;
    endtask

    task automatic mem_read(input int widx);
        bus_access(1'b0, 32'(widx * 4), 4'hf, 32'h0, sb[widx], 1'b0);
        mem_issued++;
    endtask

    task automatic set_latency(input logic [3:0] lat, input logic [3:0] lat_eff);
        bus_access(1'b1, reg_adr(REG_CFG), 4'hf, {23'h0, 1'b1, 4'h0, lat}, 32'h0, 1'b0);
        exp_lat = lat_eff;
        bus_access(1'b0, reg_adr(REG_CFG), 4'hf, 32'h0, {23'h0, 1'b1, 4'h0, lat_eff}, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h4455));
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 32'h0;
        wb_sel = 4'h0;
        wb_dat = 32'h0;
        exp_dat = 32'h0;
        exp_err = 1'b0;
        chk_rd = 1'b0;
        exp_lat = 4'd6;
        data_errs = 0;
        resp_errs = 0;
        lat_errs = 0;
        bus_errs = 0;
        mem_issued = 0;
        cycles = 0;
        repeat (8) @(posedge sys_clk);
        #0.5;
        rst_n = 1'b1;
        @(posedge sys_clk);
        #0.5;

        // Reset values
        bus_access(1'b0, reg_adr(REG_CFG), 4'hf, 32'h0, 32'h0000_0106, 1'b0);
        bus_access(1'b0, reg_adr(REG_STATUS), 4'hf, 32'h0, 32'h0, 1'b0);

        for (int i = 0; i < 8; i++) begin
            mem_write((i * 37 + 5) % 1024, 4'hf, $urandom);
        end
        for (int i = 0; i < 8; i++) begin
            mem_read((i * 37 + 5) % 1024);
        end

        // Partial byte enables on top of a full word
        for (int i = 0; i < 4; i++) begin
            idx = 300 + i * 11;
            sel = 4'($urandom % 15) + 4'd1;
            val = $urandom;
            mem_write(idx, 4'hf, $urandom);
            mem_write(idx, sel, val);
            mem_read(idx);
        end

        set_latency(4'd3, 4'd3);
        mem_write(700, 4'hf, $urandom);
        mem_read(700);
        set_latency(4'd7, 4'd7);
        mem_write(701, 4'hf, $urandom);
        mem_read(701);
        set_latency(4'd1, 4'd3);
        mem_write(702, 4'hf, $urandom);
        mem_read(702);

        bus_access(1'b0, reg_adr(REG_STATUS), 4'hf, 32'h0, 32'(mem_issued), 1'b0);

        // Error responses leave the registers alone
        bus_access(1'b1, reg_adr(REG_STATUS), 4'hf, 32'hffff_ffff, 32'h0, 1'b1);
        bus_access(1'b0, reg_adr(8'h08), 4'hf, 32'h0, 32'h0, 1'b1);
        bus_access(1'b1, reg_adr(8'h0c), 4'hf, 32'h0000_0005, 32'h0, 1'b1);
        bus_access(1'b0, reg_adr(8'h00) | 32'h100, 4'hf, 32'h0, 32'h0, 1'b1);
        bus_access(1'b0, 32'h0000_0042, 4'hf, 32'h0, 32'h0, 1'b1);
        bus_access(1'b0, reg_adr(REG_CFG), 4'hf, 32'h0, 32'h0000_0103, 1'b0);
        bus_access(1'b0, reg_adr(REG_STATUS), 4'hf, 32'h0, 32'(mem_issued), 1'b0);

        repeat (4) @(posedge sys_clk);
        $display("errors: data %0d, response %0d, latency %0d, bus %0d",
                 data_errs, resp_errs, lat_errs, bus_errs);
        if (data_errs + resp_errs + lat_errs + bus_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/hyper_pkg.sv
rtl/hyper_cfg_regs.sv
rtl/hyper_txn_engine.sv
rtl/hyper_wb_resp.sv
rtl/hyper_ctrl_top.sv
verif/hyper_mem_model.sv
verif/hyper_ctrl_properties.sv
verif/hyper_ctrl_tb.sv

//--- Bender.yml
package:
  name: hyper_ctrl

sources:
  - files:
      - rtl/hyper_pkg.sv
      - rtl/hyper_cfg_regs.sv
      - rtl/hyper_txn_engine.sv
      - rtl/hyper_wb_resp.sv
      - rtl/hyper_ctrl_top.sv
  - target: simulation
    files:
      - verif/hyper_mem_model.sv
      - verif/hyper_ctrl_properties.sv
      - verif/hyper_ctrl_tb.sv
